// ==== source/reverbPkg.sv ====
package reverbPkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------

	localparam int AddrWidth = 10;

	// Q15 audio word, coefficient or buffer word
	typedef logic signed [15:0] sample_t;
	typedef logic [AddrWidth-1:0] wordAddr_t;
	typedef logic [3:0] regAddr_t;
	// Position inside one sample frame
	typedef logic [4:0] step_t;

	// Q15 unity and minus unity
	localparam sample_t QOne = 16'sh7FFF;
	localparam sample_t QNegOne = 16'sh8000;

	// ------------------------------------------------------------------------
	// Host register map
	// ------------------------------------------------------------------------

	localparam regAddr_t RegVIn = 4'd0;
	localparam regAddr_t RegVWall = 4'd1;
	localparam regAddr_t RegVIir = 4'd2;
	localparam regAddr_t RegVComb1 = 4'd3;
	localparam regAddr_t RegVComb2 = 4'd4;
	localparam regAddr_t RegVApf = 4'd5;
	localparam regAddr_t RegDSame = 4'd6;
	localparam regAddr_t RegMSame = 4'd7;
	localparam regAddr_t RegMComb1 = 4'd8;
	localparam regAddr_t RegMComb2 = 4'd9;
	localparam regAddr_t RegMApf = 4'd10;
	localparam regAddr_t RegDApf = 4'd11;
	localparam regAddr_t RegBase = 4'd12;
	localparam regAddr_t RegEnable = 4'd13;

	// ------------------------------------------------------------------------
	// Frame schedule
	// ------------------------------------------------------------------------

	localparam int FrameSteps = 32;

	// Same-side reflection with IIR damping
	localparam step_t StepIn = 5'd0;
	localparam step_t StepWall = 5'd2;
	localparam step_t StepSubSame = 5'd4;
	localparam step_t StepIir = 5'd5;
	localparam step_t StepAddSame = 5'd6;
	localparam step_t StepWriteSame = 5'd7;
	// Comb sum
	localparam step_t StepClear = 5'd8;
	localparam step_t StepComb1 = 5'd10;
	localparam step_t StepComb2 = 5'd12;
	// All-pass stage
	localparam step_t StepApfSub = 5'd14;
	localparam step_t StepWriteApf = 5'd15;
	localparam step_t StepApfMul = 5'd16;
	localparam step_t StepApfAdd = 5'd17;
	localparam step_t StepOut = 5'd18;
	localparam step_t StepLast = step_t'(FrameSteps - 1);

	// ------------------------------------------------------------------------
	// Operand and memory selects
	// ------------------------------------------------------------------------

	typedef enum logic [3:0]
	{
		CoefZero, CoefOne, CoefNegOne, CoefIn, CoefWall,
		CoefIir, CoefComb1, CoefComb2, CoefApf, CoefNegApf
	} coefSel_e;

	typedef enum logic [1:0] {DataIn, DataRam, DataAcc} dataSel_e;

	typedef enum logic [2:0]
	{
		AdrNone, AdrDSame, AdrMSame, AdrMSameM1,
		AdrMComb1, AdrMComb2, AdrMApf, AdrApfTap
	} adrSel_e;

	typedef enum logic [1:0] {MemIdle, MemRead, MemWrite} memOp_e;

endpackage

// ==== source/reverbRegisters.sv ====
module reverbRegisters import reverbPkg::*;
(
	input logic i_clk,
	input logic i_reset,

	// Host write port
	input logic i_regWrite,
	input regAddr_t i_regAddr,
	input sample_t i_regData,

	// Q15 volumes
	output sample_t o_vIn,
	output sample_t o_vWall,
	output sample_t o_vIir,
	output sample_t o_vComb1,
	output sample_t o_vComb2,
	output sample_t o_vApf,

	// Word offsets inside the ring
	output wordAddr_t o_dSame,
	output wordAddr_t o_mSame,
	output wordAddr_t o_mComb1,
	output wordAddr_t o_mComb2,
	output wordAddr_t o_mApf,
	output wordAddr_t o_dApf,

	output wordAddr_t o_base,
	output logic o_enable
);

	// Offsets and base only keep the low word-address bits
	wordAddr_t wordValue;

	assign wordValue = i_regData[AddrWidth-1:0];

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_vIn <= '0;
			o_vWall <= '0;
			o_vIir <= '0;
			o_vComb1 <= '0;
			o_vComb2 <= '0;
			o_vApf <= '0;
			o_dSame <= '0;
			o_mSame <= '0;
			o_mComb1 <= '0;
			o_mComb2 <= '0;
			o_mApf <= '0;
			o_dApf <= '0;
			o_base <= '0;
			// Reverb starts disabled
			o_enable <= 1'b0;
		end
		else if (i_regWrite)
		begin
			case (i_regAddr)
				RegVIn: o_vIn <= i_regData;
				RegVWall: o_vWall <= i_regData;
				RegVIir: o_vIir <= i_regData;
				RegVComb1: o_vComb1 <= i_regData;
				RegVComb2: o_vComb2 <= i_regData;
				RegVApf: o_vApf <= i_regData;
				RegDSame: o_dSame <= wordValue;
				RegMSame: o_mSame <= wordValue;
				RegMComb1: o_mComb1 <= wordValue;
				RegMComb2: o_mComb2 <= wordValue;
				RegMApf: o_mApf <= wordValue;
				RegDApf: o_dApf <= wordValue;
				RegBase: o_base <= wordValue;
				RegEnable: o_enable <= i_regData[0];
				// Indices 14 and 15 are unmapped
				default:
				begin
				end
			endcase
		end
	end

endmodule

// ==== source/reverbSequencer.sv ====
module reverbSequencer import reverbPkg::*;
(
	input logic i_clk,
	input logic i_reset,

	input logic i_sampleStrobe,
	output logic o_busy,
	output step_t o_step,

	// Datapath controls, decoded from the current step
	output coefSel_e o_coefSel,
	output dataSel_e o_dataSel,
	output logic o_accAdd,

	// Memory controls, one cycle behind the step that issued them
	output adrSel_e o_adrSel,
	output memOp_e o_memOp,

	output logic o_holdSame,
	output logic o_holdTap,
	output logic o_outLoad,
	output logic o_frameDone
);

	typedef enum logic {Idle, Run} state_e;

	state_e state;
	step_t step;
	adrSel_e adrSelNext;
	memOp_e memOpNext;

	// ------------------------------------------------------------------------
	// Frame FSM and step counter
	// ------------------------------------------------------------------------

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= Idle;
			step <= '0;
		end
		else if (state == Idle)
		begin
			// Accepted strobe, step 0 follows
			if (i_sampleStrobe)
			begin
				state <= Run;
				step <= '0;
			end
		end
		else
		begin
			step <= step + 1'b1;
			if (step == StepLast)
			begin
				state <= Idle;
			end
		end
	end

	assign o_busy = (state == Run);
	assign o_step = step;

	// ------------------------------------------------------------------------
	// Step decode
	// ------------------------------------------------------------------------

	always_comb
	begin
		// Keep the accumulator alive by adding zero
		o_coefSel = CoefZero;
		o_dataSel = DataAcc;
		o_accAdd = 1'b1;
		adrSelNext = AdrNone;
		memOpNext = MemIdle;
		o_holdSame = 1'b0;
		o_holdTap = 1'b0;
		o_outLoad = 1'b0;
		o_frameDone = 1'b0;

		if (state == Run)
		begin
			case (step)
				// acc = vIn * lineIn, fetch R(dSame)
				StepIn:
				begin
					o_coefSel = CoefIn;
					o_dataSel = DataIn;
					o_accAdd = 1'b0;
					adrSelNext = AdrDSame;
					memOpNext = MemRead;
				end
				// acc += vWall * R(dSame), fetch R(mSame - 1)
				StepWall:
				begin
					o_coefSel = CoefWall;
					o_dataSel = DataRam;
					adrSelNext = AdrMSameM1;
					memOpNext = MemRead;
				end
				// acc -= R(mSame - 1), keep that word for step 6
				StepSubSame:
				begin
					o_coefSel = CoefNegOne;
					o_dataSel = DataRam;
					o_holdSame = 1'b1;
				end
				StepIir:
				begin
					o_coefSel = CoefIir;
					o_accAdd = 1'b0;
				end
				// One with DataRam takes the held word
				StepAddSame:
				begin
					o_coefSel = CoefOne;
					o_dataSel = DataRam;
				end
				StepWriteSame:
				begin
					adrSelNext = AdrMSame;
					memOpNext = MemWrite;
				end
				// Zero times acc without add clears it
				StepClear:
				begin
					o_accAdd = 1'b0;
					adrSelNext = AdrMComb1;
					memOpNext = MemRead;
				end
				StepComb1:
				begin
					o_coefSel = CoefComb1;
					o_dataSel = DataRam;
					o_accAdd = 1'b0;
					adrSelNext = AdrMComb2;
					memOpNext = MemRead;
				end
				StepComb2:
				begin
					o_coefSel = CoefComb2;
					o_dataSel = DataRam;
					adrSelNext = AdrApfTap;
					memOpNext = MemRead;
				end
				// acc -= vApf * tap, tap kept for step 17
				StepApfSub:
				begin
					o_coefSel = CoefNegApf;
					o_dataSel = DataRam;
					o_holdTap = 1'b1;
				end
				StepWriteApf:
				begin
					adrSelNext = AdrMApf;
					memOpNext = MemWrite;
				end
				StepApfMul:
				begin
					o_coefSel = CoefApf;
					o_accAdd = 1'b0;
				end
				StepApfAdd:
				begin
					o_coefSel = CoefOne;
					o_dataSel = DataRam;
				end
				StepOut: o_outLoad = 1'b1;
				StepLast: o_frameDone = 1'b1;
				default:
				begin
				end
			endcase
		end
	end

	// Memory command register, RAM data lands two steps after issue
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_adrSel <= AdrNone;
			o_memOp <= MemIdle;
		end
		else
		begin
			o_adrSel <= adrSelNext;
			o_memOp <= memOpNext;
		end
	end

endmodule

// ==== source/reverbDatapath.sv ====
module reverbDatapath import reverbPkg::*;
(
	input logic i_clk,
	input logic i_reset,

	input logic i_sampleStrobe,
	input sample_t i_lineIn,

	input sample_t i_vIn,
	input sample_t i_vWall,
	input sample_t i_vIir,
	input sample_t i_vComb1,
	input sample_t i_vComb2,
	input sample_t i_vApf,

	input sample_t i_readData,

	input coefSel_e i_coefSel,
	input dataSel_e i_dataSel,
	input logic i_accAdd,
	input logic i_holdSame,
	input logic i_holdTap,
	input logic i_outLoad,

	output sample_t o_accValue,
	output sample_t o_reverbOut,
	output logic o_outValid
);

	sample_t lineIn;
	sample_t acc;
	sample_t prevSame;
	sample_t tap;
	// Which held word the next unity add uses
	logic useTap;
	sample_t heldWord;
	sample_t negApf;
	sample_t mulA;
	sample_t mulB;
	logic signed [31:0] product;
	sample_t productQ15;
	sample_t addBase;

	// Two's complement negate, 0x8000 stays 0x8000
	assign negApf = -i_vApf;
	assign heldWord = useTap ? tap : prevSame;

	// ------------------------------------------------------------------------
	// Operand select and Q15 MAC
	// ------------------------------------------------------------------------

	always_comb
	begin
		case (i_coefSel)
			CoefOne: mulA = QOne;
			CoefNegOne: mulA = QNegOne;
			CoefIn: mulA = i_vIn;
			CoefWall: mulA = i_vWall;
			CoefIir: mulA = i_vIir;
			CoefComb1: mulA = i_vComb1;
			CoefComb2: mulA = i_vComb2;
			CoefApf: mulA = i_vApf;
			CoefNegApf: mulA = negApf;
			default: mulA = '0;
		endcase

		case (i_dataSel)
			DataIn: mulB = lineIn;
			// Unity adds replay the held word, everything else sees the RAM
			DataRam: mulB = (i_coefSel == CoefOne) ? heldWord : i_readData;
			default: mulB = acc;
		endcase
	end

	assign product = mulA * mulB;
	// Arithmetic shift by 15, kept to 16 bits
	assign productQ15 = product[30:15];
	assign addBase = i_accAdd ? acc : '0;

	// No clamp, the sum wraps
	always_ff @(posedge i_clk)
	begin
		acc <= addBase + productQ15;
	end

	assign o_accValue = acc;

	// ------------------------------------------------------------------------
	// Holding registers and output
	// ------------------------------------------------------------------------

	always_ff @(posedge i_clk)
	begin
		if (i_sampleStrobe)
		begin
			lineIn <= i_lineIn;
		end
		if (i_holdSame)
		begin
			prevSame <= i_readData;
		end
		if (i_holdTap)
		begin
			tap <= i_readData;
		end
		if (i_outLoad)
		begin
			o_reverbOut <= acc;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			useTap <= 1'b0;
			o_outValid <= 1'b0;
		end
		else
		begin
			if (i_holdSame)
			begin
				useTap <= 1'b0;
			end
			else if (i_holdTap)
			begin
				useTap <= 1'b1;
			end
			o_outValid <= i_outLoad;
		end
	end

endmodule

// ==== source/reverbAddressWrap.sv ====
module reverbAddressWrap import reverbPkg::*;
#(
	parameter int BufferDepth = 1024
)
(
	input logic i_clk,
	input logic i_reset,
	input logic i_frameDone,
	input adrSel_e i_adrSel,

	input wordAddr_t i_dSame,
	input wordAddr_t i_mSame,
	input wordAddr_t i_mComb1,
	input wordAddr_t i_mComb2,
	input wordAddr_t i_mApf,
	input wordAddr_t i_dApf,
	input wordAddr_t i_base,

	output wordAddr_t o_memAddr
);

	// One extra bit, the ring can be the full depth
	localparam logic [AddrWidth:0] DepthWide = (AddrWidth + 1)'(BufferDepth);

	logic [AddrWidth:0] ringLen;
	logic [AddrWidth:0] countInc;
	logic [AddrWidth:0] offset;
	logic [AddrWidth:0] sum;
	logic [AddrWidth:0] wrapped;
	wordAddr_t ringCount;

	assign ringLen = DepthWide - {1'b0, i_base};
	assign countInc = {1'b0, ringCount} + 1'b1;

	// Ring counter moves one word per frame
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			ringCount <= '0;
		end
		else if (i_frameDone)
		begin
			ringCount <= (countInc >= ringLen) ? '0 : countInc[AddrWidth-1:0];
		end
	end

	// Offset within the ring, minus forms wrap back by the ring length
	always_comb
	begin
		case (i_adrSel)
			AdrDSame: offset = {1'b0, i_dSame};
			AdrMSame: offset = {1'b0, i_mSame};
			AdrMSameM1: offset = (i_mSame == '0) ? ringLen - 1'b1 : {1'b0, i_mSame} - 1'b1;
			AdrMComb1: offset = {1'b0, i_mComb1};
			AdrMComb2: offset = {1'b0, i_mComb2};
			AdrMApf: offset = {1'b0, i_mApf};
			AdrApfTap: offset = (i_mApf >= i_dApf) ? {1'b0, i_mApf} - {1'b0, i_dApf} :
				{1'b0, i_mApf} + ringLen - {1'b0, i_dApf};
			default: offset = '0;
		endcase
	end

	// Both terms are below the ring length, one subtraction is enough
	assign sum = offset + {1'b0, ringCount};
	assign wrapped = (sum >= ringLen) ? sum - ringLen : sum;
	assign o_memAddr = wrapped[AddrWidth-1:0] + i_base;

endmodule

// ==== source/reverbBufferRam.sv ====
module reverbBufferRam import reverbPkg::*;
#(
	parameter int BufferDepth = 1024
)
(
	input logic i_clk,
	input memOp_e i_memOp,
	input logic i_enable,
	input wordAddr_t i_memAddr,
	input sample_t i_writeData,
	output sample_t o_readData
);

	// Work memory of the reverb
	sample_t mem [BufferDepth];

	// Silent buffer at power up
	initial
	begin
		for (int i = 0; i < BufferDepth; i++)
		begin
			mem[i] = '0;
		end
	end

	// ------------------------------------------------------------------------
	// Single port access
	// ------------------------------------------------------------------------

	always_ff @(posedge i_clk)
	begin
		case (i_memOp)
			MemRead:
			begin
				o_readData <= mem[i_memAddr];
			end
			// Write-back only happens with reverb on
			MemWrite:
			begin
				if (i_enable)
				begin
					mem[i_memAddr] <= i_writeData;
				end
			end
			default:
			begin
			end
		endcase
	end

endmodule

// ==== source/reverbUnit.sv ====
module reverbUnit import reverbPkg::*;
#(
	parameter int BufferDepth = 1024
)
(
	input logic i_clk,
	input logic i_reset,

	// Host register port
	input logic i_regWrite,
	input regAddr_t i_regAddr,
	input sample_t i_regData,

	// Sample frames
	input logic i_sampleStrobe,
	input sample_t i_lineIn,
	output logic o_busy,
	output sample_t o_reverbOut,
	output logic o_outValid
);

	sample_t vIn;
	sample_t vWall;
	sample_t vIir;
	sample_t vComb1;
	sample_t vComb2;
	sample_t vApf;
	wordAddr_t dSame;
	wordAddr_t mSame;
	wordAddr_t mComb1;
	wordAddr_t mComb2;
	wordAddr_t mApf;
	wordAddr_t dApf;
	wordAddr_t base;
	logic enable;

	coefSel_e coefSel;
	dataSel_e dataSel;
	logic accAdd;
	adrSel_e adrSel;
	memOp_e memOp;
	logic holdSame;
	logic holdTap;
	logic outLoad;
	logic frameDone;

	wordAddr_t memAddr;
	sample_t readData;
	sample_t accValue;

	// ------------------------------------------------------------------------
	// Input side
	// ------------------------------------------------------------------------

	reverbRegisters registers (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_regWrite(i_regWrite), .i_regAddr(i_regAddr), .i_regData(i_regData),
		.o_vIn(vIn), .o_vWall(vWall), .o_vIir(vIir),
		.o_vComb1(vComb1), .o_vComb2(vComb2), .o_vApf(vApf),
		.o_dSame(dSame), .o_mSame(mSame), .o_mComb1(mComb1),
		.o_mComb2(mComb2), .o_mApf(mApf), .o_dApf(dApf),
		.o_base(base), .o_enable(enable)
	);

	// ------------------------------------------------------------------------
	// Processing
	// ------------------------------------------------------------------------

	reverbSequencer sequencer (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_sampleStrobe(i_sampleStrobe), .o_busy(o_busy), .o_step(),
		.o_coefSel(coefSel), .o_dataSel(dataSel), .o_accAdd(accAdd),
		.o_adrSel(adrSel), .o_memOp(memOp),
		.o_holdSame(holdSame), .o_holdTap(holdTap),
		.o_outLoad(outLoad), .o_frameDone(frameDone)
	);

	reverbDatapath datapath (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_sampleStrobe(i_sampleStrobe), .i_lineIn(i_lineIn),
		.i_vIn(vIn), .i_vWall(vWall), .i_vIir(vIir),
		.i_vComb1(vComb1), .i_vComb2(vComb2), .i_vApf(vApf),
		.i_readData(readData),
		.i_coefSel(coefSel), .i_dataSel(dataSel), .i_accAdd(accAdd),
		.i_holdSame(holdSame), .i_holdTap(holdTap), .i_outLoad(outLoad),
		.o_accValue(accValue), .o_reverbOut(o_reverbOut), .o_outValid(o_outValid)
	);

	reverbAddressWrap #(.BufferDepth(BufferDepth)) addressWrap (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_frameDone(frameDone), .i_adrSel(adrSel),
		.i_dSame(dSame), .i_mSame(mSame), .i_mComb1(mComb1),
		.i_mComb2(mComb2), .i_mApf(mApf), .i_dApf(dApf),
		.i_base(base), .o_memAddr(memAddr)
	);

	// ------------------------------------------------------------------------
	// Output side
	// ------------------------------------------------------------------------

	reverbBufferRam #(.BufferDepth(BufferDepth)) bufferRam (
		.i_clk(i_clk), .i_memOp(memOp), .i_enable(enable),
		.i_memAddr(memAddr), .i_writeData(accValue), .o_readData(readData)
	);

endmodule

// ==== dv/reverbUnitChecker.sv ====
module reverbUnitChecker import reverbPkg::*;
#(
	parameter int BufferDepth = 1024
)
(
	input logic i_clk,
	input logic i_reset,
	input logic i_busy,
	input logic i_outValid,
	input memOp_e i_memOp,
	input logic i_enable,
	input wordAddr_t i_memAddr,
	input wordAddr_t i_base,
	input sample_t i_mem [BufferDepth]
);

	// Word seen before a gated write, compared one edge later
	logic gatedWrite;
	wordAddr_t gatedAddr;
	sample_t gatedWord;

	always_ff @(posedge i_clk)
	begin
		gatedWrite <= !i_reset && (i_memOp == MemWrite) && !i_enable;
		gatedAddr <= i_memAddr;
		gatedWord <= i_mem[i_memAddr];
	end

	// ------------------------------------------------------------------------
	// Properties
	// ------------------------------------------------------------------------

	// Valid is a single cycle pulse
	validPulse: assert property (@(posedge i_clk) disable iff (i_reset)
		i_outValid |=> !i_outValid)
		else $error("output valid held for two cycles");

	// Accesses stay inside the ring
	addrAboveBase: assert property (@(posedge i_clk) disable iff (i_reset)
		(i_memOp != MemIdle) |-> (i_memAddr >= i_base))
		else $error("buffer address below ring base");

	gatedNoWrite: assert property (@(posedge i_clk) disable iff (i_reset)
		gatedWrite |-> (i_mem[gatedAddr] == gatedWord))
		else $error("buffer written while reverb disabled");

	idleAfterReset: assert property (@(posedge i_clk)
		i_reset |=> !i_busy)
		else $error("busy high right after reset");

endmodule

bind reverbUnit reverbUnitChecker #(.BufferDepth(BufferDepth)) unitChecker (
	.i_clk(i_clk), .i_reset(i_reset), .i_busy(o_busy), .i_outValid(o_outValid),
	.i_memOp(memOp), .i_enable(enable), .i_memAddr(memAddr), .i_base(base),
	.i_mem(bufferRam.mem)
);

// ==== dv/reverbUnitMonitor.sv ====
module reverbUnitMonitor import reverbPkg::*;
#(
	parameter int BufferDepth = 1024
)
(
	input logic i_clk,
	input logic i_reset,
	input logic i_regWrite,
	input regAddr_t i_regAddr,
	input sample_t i_regData,
	input logic i_sampleStrobe,
	input sample_t i_lineIn,
	input logic i_busy,
	input sample_t i_reverbOut,
	input logic i_outValid,
	output int o_errors,
	output int o_frames
);

	// Valid rises 19 edges after the strobe edge, seen here one edge later
	localparam int ValidSeenAt = 20;
	// Busy falls 32 edges after the strobe edge, seen here one edge later
	localparam int BusyLowAt = 33;

	sample_t vIn;
	sample_t vWall;
	sample_t vIir;
	sample_t vComb1;
	sample_t vComb2;
	sample_t vApf;
	int dSame;
	int mSame;
	int mComb1;
	int mComb2;
	int mApf;
	int dApf;
	int base;
	bit enable;
	int ringCount;
	longint cycle;
	// Frame in flight and the edge that accepted it
	bit inFrame;
	longint frameStart;
	// Model copy of the work buffer
	sample_t buffer [BufferDepth];
	sample_t expected [$];
	longint due [$];

	// Q15 product, arithmetic shift by 15, low 16 bits kept
	function automatic sample_t q15(input sample_t a, input sample_t b);
		logic signed [31:0] p;
		p = a * b;
		return sample_t'(p >>> 15);
	endfunction

	function automatic int ringAddr(input int offset);
		int len;
		int s;
		len = BufferDepth - base;
		s = offset + ringCount;
		if (s >= len)
		begin
			s = s - len;
		end
		return (s + base) % BufferDepth;
	endfunction

	// One full frame of the reverb schedule
	function automatic sample_t runModel(input sample_t line);
		int len;
		int sameM1;
		int tapOff;
		sample_t acc;
		sample_t ps;
		sample_t tap;
		len = BufferDepth - base;
		sameM1 = (mSame == 0) ? len - 1 : mSame - 1;
		tapOff = (mApf >= dApf) ? mApf - dApf : mApf + len - dApf;
		// Same side reflection with damping
		acc = q15(vIn, line);
		acc = acc + q15(vWall, buffer[ringAddr(dSame)]);
		ps = buffer[ringAddr(sameM1)];
		acc = acc + q15(16'sh8000, ps);
		acc = q15(vIir, acc);
		acc = acc + q15(16'sh7FFF, ps);
		if (enable)
		begin
			buffer[ringAddr(mSame)] = acc;
		end
		// Comb sum
		acc = q15(vComb1, buffer[ringAddr(mComb1)]);
		acc = acc + q15(vComb2, buffer[ringAddr(mComb2)]);
		// All-pass
		tap = buffer[ringAddr(tapOff)];
		acc = acc + q15(-vApf, tap);
		if (enable)
		begin
			buffer[ringAddr(mApf)] = acc;
		end
		acc = q15(vApf, acc);
		acc = acc + q15(16'sh7FFF, tap);
		// Ring advances once per frame
		ringCount = ringCount + 1;
		if (ringCount >= len)
		begin
			ringCount = 0;
		end
		return acc;
	endfunction

	initial
	begin
		for (int i = 0; i < BufferDepth; i++)
		begin
			buffer[i] = '0;
		end
		o_errors = 0;
		o_frames = 0;
		cycle = 0;
		inFrame = 1'b0;
		frameStart = 0;
	end

	// ------------------------------------------------------------------------
	// Watch the DUT ports
	// ------------------------------------------------------------------------

	always @(posedge i_clk)
	begin
		cycle = cycle + 1;
		if (i_reset)
		begin
			// Buffer keeps its content over reset
			{vIn, vWall, vIir, vComb1, vComb2, vApf} = '0;
			{dSame, mSame, mComb1, mComb2, mApf, dApf, base} = '0;
			enable = 1'b0;
			ringCount = 0;
			inFrame = 1'b0;
		end
		else
		begin
			if (i_regWrite)
			begin
				case (i_regAddr)
					RegVIn: vIn = i_regData;
					RegVWall: vWall = i_regData;
					RegVIir: vIir = i_regData;
					RegVComb1: vComb1 = i_regData;
					RegVComb2: vComb2 = i_regData;
					RegVApf: vApf = i_regData;
					RegDSame: dSame = int'(i_regData[AddrWidth-1:0]);
					RegMSame: mSame = int'(i_regData[AddrWidth-1:0]);
					RegMComb1: mComb1 = int'(i_regData[AddrWidth-1:0]);
					RegMComb2: mComb2 = int'(i_regData[AddrWidth-1:0]);
					RegMApf: mApf = int'(i_regData[AddrWidth-1:0]);
					RegDApf: dApf = int'(i_regData[AddrWidth-1:0]);
					RegBase: base = int'(i_regData[AddrWidth-1:0]);
					RegEnable: enable = i_regData[0];
					default:
					begin
					end
				endcase
			end
			// Busy holds for the whole frame and drops on schedule
			if (inFrame)
			begin
				if (cycle == frameStart + BusyLowAt)
				begin
					if (i_busy)
					begin
						o_errors = o_errors + 1;
						$display("mismatch at %0t: busy still high %0d cycles after the strobe",
							$time, cycle - frameStart - 1);
					end
					inFrame = 1'b0;
				end
				else if (!i_busy)
				begin
					o_errors = o_errors + 1;
					$display("mismatch at %0t: busy low %0d cycles after the strobe",
						$time, cycle - frameStart - 1);
					inFrame = 1'b0;
				end
			end
			// Strobes while busy are dropped
			if (i_sampleStrobe && !i_busy)
			begin
				expected.push_back(runModel(i_lineIn));
				due.push_back(cycle + ValidSeenAt);
				o_frames = o_frames + 1;
				inFrame = 1'b1;
				frameStart = cycle;
			end
			if (i_outValid)
			begin
				if (expected.size() == 0)
				begin
					o_errors = o_errors + 1;
					$display("Output valid came with no accepted frame pending");
				end
				else
				begin
					if (i_reverbOut !== expected[0])
					begin
						o_errors = o_errors + 1;
						$display("mismatch at %0t: sample expected %h got %h",
							$time, expected[0], i_reverbOut);
					end
					if (cycle != due[0])
					begin
						o_errors = o_errors + 1;
						$display("mismatch at %0t: output valid %0d cycles off",
							$time, cycle - due[0]);
					end
					void'(expected.pop_front());
					void'(due.pop_front());
				end
			end
		end
	end

endmodule

// ==== dv/reverbUnitTb.sv ====
module reverbUnitTb import reverbPkg::*; ();

	localparam int BufferDepth = 1024;
	localparam int TimeoutCycles = 100;

	logic clk;
	logic reset;
	logic regWrite;
	regAddr_t regAddr;
	sample_t regData;
	logic sampleStrobe;
	sample_t lineIn;
	logic busy;
	sample_t reverbOut;
	logic outValid;

	int seed;
	int tbErrors;
	int framesSent;
	int monErrors;
	int monFrames;

	reverbUnit #(.BufferDepth(BufferDepth)) uut (
		.i_clk(clk), .i_reset(reset),
		.i_regWrite(regWrite), .i_regAddr(regAddr), .i_regData(regData),
		.i_sampleStrobe(sampleStrobe), .i_lineIn(lineIn),
		.o_busy(busy), .o_reverbOut(reverbOut), .o_outValid(outValid)
	);

	reverbUnitMonitor #(.BufferDepth(BufferDepth)) monitor (
		.i_clk(clk), .i_reset(reset),
		.i_regWrite(regWrite), .i_regAddr(regAddr), .i_regData(regData),
		.i_sampleStrobe(sampleStrobe), .i_lineIn(lineIn),
		.i_busy(busy), .i_reverbOut(reverbOut), .i_outValid(outValid),
		.o_errors(monErrors), .o_frames(monFrames)
	);

	always #10 clk = ~clk;

	// ------------------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------------------

	function automatic sample_t pickSample(input bit extreme);
		if (extreme)
		begin
			return ($random(seed) & 1) ? 16'sh7FFF : 16'sh8000;
		end
		return sample_t'($random(seed));
	endfunction

	// Offset below the ring length, optionally in its last eight words
	function automatic sample_t pickOffset(input int len, input bit nearEnd);
		int r;
		r = $random(seed) & 32'h7FFF_FFFF;
		if (nearEnd)
		begin
			return sample_t'(len - 1 - (r % 8));
		end
		return sample_t'(r % len);
	endfunction

	task automatic writeReg(input regAddr_t addr, input sample_t data);
		@(posedge clk);
		regWrite <= 1'b1;
		regAddr <= addr;
		regData <= data;
		@(posedge clk);
		regWrite <= 1'b0;
	endtask

	task automatic resetDut();
		@(posedge clk);
		reset <= 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic waitIdle();
		int cycles;
		cycles = 0;
		while (busy && cycles < TimeoutCycles)
		begin
			@(posedge clk);
			cycles++;
		end
		if (busy)
		begin
			tbErrors++;
			$display("Timeout: the unit stayed busy at %0t", $time);
		end
	endtask

	// Register set only touched between frames
	task automatic configure(input int base, input bit nearEnd, input bit extreme,
		input bit enableOn);
		int len;
		waitIdle();
		len = BufferDepth - base;
		writeReg(RegBase, sample_t'(base));
		writeReg(RegVIn, pickSample(extreme));
		writeReg(RegVWall, pickSample(extreme));
		writeReg(RegVIir, pickSample(extreme));
		writeReg(RegVComb1, pickSample(extreme));
		writeReg(RegVComb2, pickSample(extreme));
		writeReg(RegVApf, pickSample(extreme));
		writeReg(RegDSame, pickOffset(len, nearEnd));
		writeReg(RegMSame, pickOffset(len, nearEnd));
		writeReg(RegMComb1, pickOffset(len, nearEnd));
		writeReg(RegMComb2, pickOffset(len, nearEnd));
		writeReg(RegMApf, pickOffset(len, nearEnd));
		writeReg(RegDApf, pickOffset(len, nearEnd));
		writeReg(RegEnable, sample_t'(enableOn));
	endtask

	// One frame, with optional strobes while the unit is busy
	task automatic runFrame(input sample_t line, input bit extraStrobes);
		int cycles;
		bit seen;
		waitIdle();
		@(posedge clk);
		sampleStrobe <= 1'b1;
		lineIn <= line;
		@(posedge clk);
		sampleStrobe <= 1'b0;
		framesSent++;
		cycles = 1;
		if (extraStrobes)
		begin
			repeat (3) @(posedge clk);
			sampleStrobe <= 1'b1;
			lineIn <= pickSample(1'b0);
			@(posedge clk);
			sampleStrobe <= 1'b0;
			repeat (8) @(posedge clk);
			sampleStrobe <= 1'b1;
			@(posedge clk);
			sampleStrobe <= 1'b0;
			cycles = 14;
		end
		seen = 1'b0;
		while (!seen && cycles < TimeoutCycles)
		begin
			@(posedge clk);
			cycles++;
			seen = outValid;
		end
		if (!seen)
		begin
			tbErrors++;
			$display("Timeout: no output valid after a sample strobe at %0t", $time);
		end
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------

	initial
	begin
		seed = 75;
		tbErrors = 0;
		framesSent = 0;
		clk = 1'b0;
		reset = 1'b1;
		regWrite = 1'b0;
		regAddr = '0;
		regData = '0;
		sampleStrobe = 1'b0;
		lineIn = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Disabled reverb, buffer must stay silent
		configure(0, 1'b0, 1'b0, 1'b0);
		repeat (20) runFrame(pickSample(1'b0), 1'b0);

		// Enabled, base zero
		configure(0, 1'b0, 1'b0, 1'b1);
		repeat (150) runFrame(pickSample(1'b0), 1'b0);

		// Short ring above a nonzero base, offsets near its end
		// Ring shorter than the frame count, so the counter wraps too
		waitIdle();
		resetDut();
		configure(900 + (($random(seed) & 32'h7FFF_FFFF) % 100), 1'b1, 1'b0, 1'b1);
		repeat (150) runFrame(pickSample(1'b0), 1'b0);

		// Strobes while busy are ignored
		repeat (20) runFrame(pickSample(1'b0), 1'b1);

		// Full scale coefficients and inputs
		configure(0, 1'b0, 1'b1, 1'b1);
		repeat (40) runFrame(pickSample(1'b1), 1'b0);

		waitIdle();
		repeat (4) @(posedge clk);
		if (monFrames != framesSent)
		begin
			tbErrors++;
			$display("mismatch at %0t: %0d frames accepted, %0d expected",
				$time, monFrames, framesSent);
		end
		$display("Errors: testbench %0d, monitor %0d, frames %0d",
			tbErrors, monErrors, monFrames);
		if (tbErrors == 0 && monErrors == 0)
		begin
			$display("Finished with no errors");
		end
		else
		begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// ==== reverbUnit.f ====
source/reverbPkg.sv
source/reverbRegisters.sv
source/reverbSequencer.sv
source/reverbDatapath.sv
source/reverbAddressWrap.sv
source/reverbBufferRam.sv
source/reverbUnit.sv
dv/reverbUnitChecker.sv
dv/reverbUnitMonitor.sv
dv/reverbUnitTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Build the reverb testbench with Verilator, run it and grade the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f reverbUnit.f \
	--top-module reverbUnitTb -Mdir obj_dir -o reverbUnitSim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/reverbUnitSim > sim.log 2>&1
grep -q "^Finished with no errors$" sim.log && echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
